/* src/rvPkg.sv */
`default_nettype none

package rvPkg;

    localparam int XLEN = 64;
    localparam logic [XLEN-1:0] RESET_PC = 64'h0;
    localparam int DMEM_BYTES = 4096;          // addresses wrap at this size

    // major opcodes
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_IMM32  = 7'b0011011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_REG32  = 7'b0111011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // load and store widths, stores use the lower four
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_D  = 3'b011;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;
    localparam logic [2:0] F3_WU = 3'b110;

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;   // sub, sra

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rType_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iType_t;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sType_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] immHi;      // imm[10:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] immLo;      // imm[4:1]
        logic       imm11;
        logic [6:0] opcode;
    } bType_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uType_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] immLo;      // imm[10:1]
        logic       imm11;
        logic [7:0] immHi;      // imm[19:12]
        logic [4:0] rd;
        logic [6:0] opcode;
    } jType_t;

    typedef union packed {
        rType_t      r;
        iType_t      i;
        sType_t      s;
        bType_t      b;
        uType_t      u;
        jType_t      j;
        logic [31:0] raw;
    } instWord_t;

    typedef struct packed {
        logic [XLEN-1:0] immI;
        logic [XLEN-1:0] immS;
        logic [XLEN-1:0] immB;
        logic [XLEN-1:0] immU;
        logic [XLEN-1:0] immJ;
        logic [2:0]      funct3;
        logic [6:0]      funct7;
    } immSet_t;

    typedef struct packed {
        logic            en;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] data;   // already lane-shifted
        logic [7:0]      mask;
    } storeReq_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        instWord_t       inst;
        logic            wen;
        logic [4:0]      rd;
        logic [XLEN-1:0] wdata;
        logic [XLEN-1:0] nextPc;
    } retire_t;

endpackage

`default_nettype wire

/* src/immDecode.sv */
`timescale 1ns/10ps
`default_nettype none

module immDecode (
    input  rvPkg::instWord_t inst,
    output rvPkg::immSet_t   imm
);
    import rvPkg::*;

    always_comb begin
        imm.immI = {{(XLEN-12){inst.i.imm[11]}}, inst.i.imm};
        imm.immS = {{(XLEN-12){inst.s.immHi[6]}}, inst.s.immHi, inst.s.immLo};
        imm.immB = {
            {(XLEN-12){inst.b.imm12}},
            inst.b.imm11,
            inst.b.immHi,
            inst.b.immLo,
            1'b0
        };
        imm.immU = {{(XLEN-32){inst.u.imm[19]}}, inst.u.imm, 12'b0};
        imm.immJ = {
            {(XLEN-20){inst.j.imm20}},
            inst.j.immHi,
            inst.j.imm11,
            inst.j.immLo,
            1'b0
        };
        imm.funct3 = inst.r.funct3;
        imm.funct7 = inst.r.funct7;
    end

endmodule

`default_nettype wire

/* src/regFile.sv */
`timescale 1ns/10ps
`default_nettype none

module regFile (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [4:0]             rs1Addr,
    input  logic [4:0]             rs2Addr,
    output logic [rvPkg::XLEN-1:0] rs1Data,
    output logic [rvPkg::XLEN-1:0] rs2Data,
    input  logic                   wen,
    input  logic [4:0]             rd,
    input  logic [rvPkg::XLEN-1:0] wdata
);
    import rvPkg::*;

    logic [XLEN-1:0] regs [32];

    // x0 always reads zero
    assign rs1Data = (rs1Addr == 5'd0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == 5'd0) ? '0 : regs[rs2Addr];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (wen && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

endmodule

`default_nettype wire

/* src/execUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module execUnit (
    input  logic [rvPkg::XLEN-1:0] pc,
    input  rvPkg::instWord_t       inst,
    input  rvPkg::immSet_t         imm,
    input  logic [rvPkg::XLEN-1:0] rs1,
    input  logic [rvPkg::XLEN-1:0] rs2,
    input  logic [rvPkg::XLEN-1:0] loadData,
    output logic [rvPkg::XLEN-1:0] loadAddr,
    output logic                   rdWen,
    output logic [rvPkg::XLEN-1:0] rdData,
    output logic [rvPkg::XLEN-1:0] nextPc,
    output rvPkg::storeReq_t       store
);
    import rvPkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            regForm;
    logic            wordForm;
    logic            altOp;
    logic            aluOk;
    logic            loadOk;
    logic            taken;
    logic [XLEN-1:0] opB;
    logic [XLEN-1:0] aluRes;
    logic [XLEN-1:0] sraRes;
    logic [31:0]     wordRes;
    logic [31:0]     sraWord;
    logic [XLEN-1:0] pcPlus4;
    logic [XLEN-1:0] storeAddr;
    logic [7:0]      storeMask;

    assign opcode    = inst.r.opcode;
    assign funct3    = imm.funct3;
    assign funct7    = imm.funct7;
    assign regForm   = (opcode == OP_REG) || (opcode == OP_REG32);
    assign wordForm  = (opcode == OP_IMM32) || (opcode == OP_REG32);
    assign altOp     = funct7[5];                 // sub / sra select
    assign opB       = regForm ? rs2 : imm.immI;
    assign pcPlus4   = pc + 64'd4;
    assign loadAddr  = rs1 + imm.immI;
    assign storeAddr = rs1 + imm.immS;
    assign sraRes    = $signed(rs1) >>> opB[5:0];
    assign sraWord   = $signed(rs1[31:0]) >>> opB[4:0];
    assign loadOk    = funct3 inside {F3_B, F3_H, F3_W, F3_D, F3_BU, F3_HU, F3_WU};

    // legal funct7 per form
    always_comb begin
        aluOk = 1'b1;
        if (regForm) begin
            aluOk = (funct7 == F7_BASE) ||
                    (funct7 == F7_ALT && (funct3 == F3_ADD || funct3 == F3_SR));
        end else if (!wordForm) begin
            if (funct3 == F3_SLL) begin
                aluOk = funct7[6:1] == F7_BASE[6:1];   // 6-bit shamt
            end else if (funct3 == F3_SR) begin
                aluOk = funct7[6:1] == F7_BASE[6:1] || funct7[6:1] == F7_ALT[6:1];
            end
        end else if (funct3 != F3_ADD) begin
            aluOk = (funct7 == F7_BASE) || (funct7 == F7_ALT && funct3 == F3_SR);
        end
        if (wordForm && !(funct3 inside {F3_ADD, F3_SLL, F3_SR})) begin
            aluOk = 1'b0;
        end
    end

    always_comb begin
        case (funct3)
            F3_ADD:  aluRes = (regForm && altOp) ? rs1 - opB : rs1 + opB;
            F3_SLL:  aluRes = rs1 << opB[5:0];
            F3_SLT:  aluRes = {63'b0, $signed(rs1) < $signed(opB)};
            F3_SLTU: aluRes = {63'b0, rs1 < opB};
            F3_XOR:  aluRes = rs1 ^ opB;
            F3_SR:   aluRes = altOp ? sraRes : rs1 >> opB[5:0];
            F3_OR:   aluRes = rs1 | opB;
            default: aluRes = rs1 & opB;
        endcase
        case (funct3)
            F3_SLL:  wordRes = rs1[31:0] << opB[4:0];
            F3_SR:   wordRes = altOp ? sraWord : rs1[31:0] >> opB[4:0];
            default: wordRes = (regForm && altOp) ? rs1[31:0] - opB[31:0]
                                                  : rs1[31:0] + opB[31:0];
        endcase
    end

    always_comb begin
        case (funct3)
            F3_BEQ:  taken = rs1 == rs2;
            F3_BNE:  taken = rs1 != rs2;
            F3_BLT:  taken = $signed(rs1) < $signed(rs2);
            F3_BGE:  taken = $signed(rs1) >= $signed(rs2);
            F3_BLTU: taken = rs1 < rs2;
            F3_BGEU: taken = rs1 >= rs2;
            default: taken = 1'b0;
        endcase
        case (funct3)
            F3_B:    storeMask = 8'h01;
            F3_H:    storeMask = 8'h03;
            F3_W:    storeMask = 8'h0f;
            default: storeMask = 8'hff;
        endcase
    end

    always_comb begin
        rdWen  = 1'b0;
        rdData = aluRes;
        nextPc = pcPlus4;
        store  = '0;
        case (opcode)
            OP_LUI: begin
                rdWen  = 1'b1;
                rdData = imm.immU;
            end
            OP_AUIPC: begin
                rdWen  = 1'b1;
                rdData = pc + imm.immU;
            end
            OP_JAL: begin
                rdWen  = 1'b1;
                rdData = pcPlus4;
                nextPc = pc + imm.immJ;
            end
            OP_JALR: begin
                if (funct3 == 3'b000) begin
                    rdWen  = 1'b1;
                    rdData = pcPlus4;
                    nextPc = (rs1 + imm.immI) & ~64'd1;
                end
            end
            OP_BRANCH: begin
                if (taken) nextPc = pc + imm.immB;
            end
            OP_LOAD: begin
                rdWen  = loadOk;
                rdData = loadData;                 // extended in loadStore
            end
            OP_STORE: begin
                if (!funct3[2]) begin
                    store.en   = 1'b1;
                    store.addr = storeAddr;
                    store.data = rs2 << {storeAddr[2:0], 3'b000};
                    store.mask = storeMask << storeAddr[2:0];
                end
            end
            OP_IMM, OP_REG: begin
                rdWen  = aluOk;
                rdData = aluRes;
            end
            OP_IMM32, OP_REG32: begin
                rdWen  = aluOk;
                rdData = {{32{wordRes[31]}}, wordRes};
            end
            default: ;                                 // unknown, just pc+4
        endcase
    end

endmodule

`default_nettype wire

/* src/loadStore.sv */
`timescale 1ns/10ps
`default_nettype none

module loadStore (
    input  logic                   clk,
    input  logic [rvPkg::XLEN-1:0] loadAddr,
    input  logic [2:0]             loadWidth,
    output logic [rvPkg::XLEN-1:0] loadData,
    input  rvPkg::storeReq_t       store
);
    import rvPkg::*;

    localparam int AW = $clog2(DMEM_BYTES);

    logic [7:0]      mem [DMEM_BYTES];
    logic [AW-1:0]   loadBase;
    logic [AW-1:0]   storeBase;
    logic [XLEN-1:0] raw;

    assign loadBase  = loadAddr[AW-1:0];
    assign storeBase = {store.addr[AW-1:3], 3'b000};   // mask is per 8-byte lane

    // gather eight bytes, wrapping at the top
    always_comb begin
        for (int k = 0; k < 8; k++) begin
            raw[8*k +: 8] = mem[loadBase + AW'(k)];
        end
    end

    always_comb begin
        case (loadWidth)
            F3_B:    loadData = {{(XLEN-8){raw[7]}}, raw[7:0]};
            F3_H:    loadData = {{(XLEN-16){raw[15]}}, raw[15:0]};
            F3_W:    loadData = {{(XLEN-32){raw[31]}}, raw[31:0]};
            F3_D:    loadData = raw;
            F3_BU:   loadData = {{(XLEN-8){1'b0}}, raw[7:0]};
            F3_HU:   loadData = {{(XLEN-16){1'b0}}, raw[15:0]};
            F3_WU:   loadData = {{(XLEN-32){1'b0}}, raw[31:0]};
            default: loadData = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (store.en) begin
            for (int k = 0; k < 8; k++) begin
                if (store.mask[k]) begin
                    mem[storeBase + AW'(k)] <= store.data[8*k +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/fetchUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module fetchUnit (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [rvPkg::XLEN-1:0] nextPc,
    input  rvPkg::instWord_t       inst,
    input  logic                   rdWen,
    input  logic [4:0]             rd,
    input  logic [rvPkg::XLEN-1:0] rdData,
    output logic [rvPkg::XLEN-1:0] pc,
    output rvPkg::retire_t         retire
);
    import rvPkg::*;

    always_ff @(posedge clk) begin
        // record of the instruction executing this cycle
        retire.pc     <= pc;
        retire.inst   <= inst;
        retire.wen    <= rdWen;
        retire.rd     <= rd;
        retire.wdata  <= rdData;
        retire.nextPc <= nextPc;
        if (!rstN) begin
            pc           <= RESET_PC;
            retire.valid <= 1'b0;
        end else begin
            pc           <= nextPc;
            retire.valid <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* src/rvCore.sv */
`timescale 1ns/10ps
`default_nettype none

module rvCore (
    input  logic                   clk,
    input  logic                   rstN,
    output logic [rvPkg::XLEN-1:0] instAddr,
    input  rvPkg::instWord_t       inst,
    output rvPkg::retire_t         retire
);
    import rvPkg::*;

    immSet_t         imm;
    storeReq_t       store;
    logic [XLEN-1:0] rs1Data;
    logic [XLEN-1:0] rs2Data;
    logic [XLEN-1:0] loadAddr;
    logic [XLEN-1:0] loadData;
    logic [XLEN-1:0] rdData;
    logic [XLEN-1:0] nextPc;
    logic            rdWen;

    fetchUnit fetch (
        .clk(clk), .rstN(rstN), .nextPc(nextPc), .inst(inst),
        .rdWen(rdWen), .rd(inst.r.rd), .rdData(rdData),
        .pc(instAddr), .retire(retire)
    );

    immDecode dec (.inst(inst), .imm(imm));

    regFile regs (
        .clk(clk), .rstN(rstN),
        .rs1Addr(inst.r.rs1), .rs2Addr(inst.r.rs2),
        .rs1Data(rs1Data), .rs2Data(rs2Data),
        .wen(rdWen), .rd(inst.r.rd), .wdata(rdData)
    );

    execUnit exec (
        .pc(instAddr), .inst(inst), .imm(imm),
        .rs1(rs1Data), .rs2(rs2Data), .loadData(loadData),
        .loadAddr(loadAddr), .rdWen(rdWen), .rdData(rdData),
        .nextPc(nextPc), .store(store)
    );

    loadStore lsu (
        .clk(clk), .loadAddr(loadAddr), .loadWidth(imm.funct3),
        .loadData(loadData), .store(store)
    );

endmodule

`default_nettype wire

/* verif/rvRefModel.svh */
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

localparam int SLOTS  = 16;                  // doublewords in the load/store window
localparam int MEM_AW = $clog2(DMEM_BYTES);

typedef struct packed {
    logic [XLEN-1:0] pc;
    instWord_t       inst;
    logic            wen;
    logic [4:0]      rd;
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] nextPc;
} stepResult_t;

logic [XLEN-1:0] modelRegs [32];
logic [7:0]      modelMem [DMEM_BYTES];
logic [XLEN-1:0] modelPc;

function automatic logic [31:0] rWord(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] iWord(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] sWord(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
endfunction

function automatic logic [31:0] bWord(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
endfunction

function automatic logic [31:0] uWord(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] op);
    return {imm, rd, op};
endfunction

function automatic logic [31:0] jWord(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
endfunction

function automatic logic isKnownOpcode(input logic [6:0] op);
    return op inside {OP_LOAD, OP_STORE, OP_IMM, OP_IMM32, OP_REG, OP_REG32,
                      OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH};
endfunction

// n counts issued instructions, the first ones set up x31 and the window
function automatic logic [31:0] nextInstruction(input int n);
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [2:0]  wf3;
    logic [11:0] imm12;
    logic [11:0] offset;
    logic [6:0]  f7;
    logic [6:0]  op;
    logic        alt;
    int          pick;
    if (n == 0) return uWord(20'h1, 5'd31, OP_LUI);
    if (n == 1) return iWord(12'h800, 5'd31, F3_ADD, 5'd31, OP_IMM);   // x31 = 0x800
    if (n < 2 + SLOTS) return sWord(12'(8 * (n - 2)), 5'd0, 5'd31, F3_D);
    rd     = 5'($urandom_range(0, 30));      // x31 stays the base
    rs1    = 5'($urandom());
    rs2    = 5'($urandom());
    f3     = 3'($urandom());
    imm12  = 12'($urandom());
    alt    = 1'($urandom());
    offset = 12'(8 * $urandom_range(0, SLOTS - 1));
    wf3    = (f3[1:0] == 2'd1) ? F3_SLL : (f3[1:0] == 2'd2) ? F3_SR : F3_ADD;
    pick   = int'($urandom_range(0, 99));
    if (pick < 20) begin
        if (f3 == F3_SLL) imm12 = {6'b0, imm12[5:0]};
        else if (f3 == F3_SR) imm12 = {alt ? 6'b010000 : 6'b0, imm12[5:0]};
        return iWord(imm12, rs1, f3, rd, OP_IMM);
    end
    if (pick < 30) begin
        if (wf3 == F3_SLL) imm12 = {7'b0, imm12[4:0]};
        else if (wf3 == F3_SR) imm12 = {alt ? F7_ALT : F7_BASE, imm12[4:0]};
        return iWord(imm12, rs1, wf3, rd, OP_IMM32);
    end
    if (pick < 53) begin
        if (pick >= 45) f3 = wf3;
        f7 = (alt && (f3 == F3_ADD || f3 == F3_SR)) ? F7_ALT : F7_BASE;
        return rWord(f7, rs2, rs1, f3, rd, pick < 45 ? OP_REG : OP_REG32);
    end
    if (pick < 57) return uWord(20'($urandom()), rd, OP_LUI);
    if (pick < 60) return uWord(20'($urandom()), rd, OP_AUIPC);
    if (pick < 63) return jWord({20'($urandom()), 1'b0}, rd);
    if (pick < 66) return iWord(imm12, rs1, 3'b000, rd, OP_JALR);
    if (pick < 76) begin
        if (f3[2:1] == 2'b01) f3 = {2'b11, f3[0]};   // no branch at 010, 011
        return bWord({imm12, 1'b0}, rs2, rs1, f3);
    end
    if (pick < 86) return iWord(offset, 5'd31, 3'($urandom_range(0, 6)), rd, OP_LOAD);
    if (pick < 95) return sWord(offset, rs2, 5'd31, {1'b0, f3[1:0]});
    do begin
        op = 7'($urandom());
    end while (isKnownOpcode(op));
    return {25'($urandom()), op};
endfunction

function automatic logic [XLEN-1:0] aluResult(input logic [2:0] f3, input logic alt,
                                              input logic [XLEN-1:0] x,
                                              input logic [XLEN-1:0] y);
    logic [XLEN-1:0] r;
    case (f3)
        F3_ADD:  r = alt ? x - y : x + y;
        F3_SLL:  r = x << y[5:0];
        F3_SLT:  r = ($signed(x) < $signed(y)) ? 64'd1 : 64'd0;
        F3_SLTU: r = (x < y) ? 64'd1 : 64'd0;
        F3_XOR:  r = x ^ y;
        F3_OR:   r = x | y;
        F3_AND:  r = x & y;
        default: begin
            if (alt) r = $signed(x) >>> y[5:0];
            else r = x >> y[5:0];
        end
    endcase
    return r;
endfunction

function automatic logic [XLEN-1:0] aluWordResult(input logic [2:0] f3, input logic alt,
                                                  input logic [XLEN-1:0] x,
                                                  input logic [XLEN-1:0] y);
    logic [31:0] v;
    case (f3)
        F3_ADD: v = alt ? x[31:0] - y[31:0] : x[31:0] + y[31:0];
        F3_SLL: v = x[31:0] << y[4:0];
        default: begin
            if (alt) v = $signed(x[31:0]) >>> y[4:0];
            else v = x[31:0] >> y[4:0];
        end
    endcase
    return {{32{v[31]}}, v};
endfunction

// expected retire record, shadow memory takes the store here
function automatic stepResult_t predict(input instWord_t w);
    stepResult_t     r;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] immI;
    logic [XLEN-1:0] immS;
    logic [XLEN-1:0] immB;
    logic [XLEN-1:0] immU;
    logic [XLEN-1:0] immJ;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] data;
    logic            taken;
    logic [2:0]      f3;
    immI = {{52{w.raw[31]}}, w.raw[31:20]};
    immS = {{52{w.raw[31]}}, w.raw[31:25], w.raw[11:7]};
    immB = {{52{w.raw[31]}}, w.raw[7], w.raw[30:25], w.raw[11:8], 1'b0};
    immU = {{32{w.raw[31]}}, w.raw[31:12], 12'b0};
    immJ = {{44{w.raw[31]}}, w.raw[19:12], w.raw[20], w.raw[30:21], 1'b0};
    f3 = w.r.funct3;
    a = modelRegs[w.r.rs1];
    b = modelRegs[w.r.rs2];
    r.pc = modelPc;
    r.inst = w;
    r.wen = 1'b0;
    r.rd = w.r.rd;
    r.wdata = '0;
    r.nextPc = modelPc + 64'd4;
    case (w.r.opcode)
        OP_LUI: begin
            r.wen = 1'b1;
            r.wdata = immU;
        end
        OP_AUIPC: begin
            r.wen = 1'b1;
            r.wdata = modelPc + immU;
        end
        OP_JAL: begin
            r.wen = 1'b1;
            r.wdata = modelPc + 64'd4;
            r.nextPc = modelPc + immJ;
        end
        OP_JALR: begin
            r.wen = 1'b1;
            r.wdata = modelPc + 64'd4;
            r.nextPc = (a + immI) & ~64'd1;
        end
        OP_BRANCH: begin
            case (f3)
                F3_BEQ:  taken = a == b;
                F3_BNE:  taken = a != b;
                F3_BLT:  taken = $signed(a) < $signed(b);
                F3_BGE:  taken = $signed(a) >= $signed(b);
                F3_BLTU: taken = a < b;
                default: taken = a >= b;
            endcase
            if (taken) r.nextPc = modelPc + immB;
        end
        OP_LOAD: begin
            addr = a + immI;
            for (int k = 0; k < 8; k++) begin
                data[8*k +: 8] = modelMem[MEM_AW'(addr + 64'(k))];
            end
            r.wen = 1'b1;
            case (f3)
                F3_B:    r.wdata = {{56{data[7]}}, data[7:0]};
                F3_H:    r.wdata = {{48{data[15]}}, data[15:0]};
                F3_W:    r.wdata = {{32{data[31]}}, data[31:0]};
                F3_BU:   r.wdata = {56'b0, data[7:0]};
                F3_HU:   r.wdata = {48'b0, data[15:0]};
                F3_WU:   r.wdata = {32'b0, data[31:0]};
                default: r.wdata = data;
            endcase
        end
        OP_STORE: begin
            addr = a + immS;
            for (int k = 0; k < (1 << f3); k++) begin
                modelMem[MEM_AW'(addr + 64'(k))] = b[8*k +: 8];
            end
        end
        OP_IMM: begin
            r.wen = 1'b1;
            r.wdata = aluResult(f3, f3 == F3_SR && w.raw[30], a, immI);
        end
        OP_REG: begin
            r.wen = 1'b1;
            r.wdata = aluResult(f3, w.raw[30], a, b);
        end
        OP_IMM32: begin
            r.wen = 1'b1;
            r.wdata = aluWordResult(f3, f3 == F3_SR && w.raw[30], a, immI);
        end
        OP_REG32: begin
            r.wen = 1'b1;
            r.wdata = aluWordResult(f3, w.raw[30], a, b);
        end
        default: ;                                   // unknown, no write
    endcase
    return r;
endfunction

`endif

/* verif/rvCoreTb.sv */
`timescale 1ns/10ps
`default_nettype none

module rvCoreTb;
    import rvPkg::*;

    localparam int     SEED        = 10463;
    localparam int     N_INST      = 3000;
    localparam int     DRIVE_DELAY = 5;     // ns after the rising edge
    localparam longint WATCHDOG_NS = (longint'(N_INST) / 10 + 1) * 1000000;  // 1 ms per 10

    logic            clk;
    logic            rstN;
    logic [XLEN-1:0] instAddr;
    instWord_t       inst;
    retire_t         retire;

    int errors = 0;
    int checks = 0;
    int checkedCount = 0;

    `include "rvRefModel.svh"

    stepResult_t expQ[$];

    rvCore DUT (
        .clk(clk),
        .rstN(rstN),
        .instAddr(instAddr),
        .inst(inst),
        .retire(retire)
    );

    always #50 clk = ~clk;

    task automatic checkValue(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    // stimulus and model
    initial begin
        logic [31:0] w;
        stepResult_t pending;
        void'($urandom(SEED));
        clk = 1'b0;
        rstN = 1'b0;
        inst = '0;
        modelPc = RESET_PC;
        for (int k = 0; k < 32; k++) begin
            modelRegs[k] = '0;
        end
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        rstN = 1'b1;
        for (int n = 0; n < N_INST; n++) begin
            if (n > 0) begin
                @(posedge clk);
                #DRIVE_DELAY;
                expQ.push_back(pending);     // executed at this edge
            end
            checkValue("instAddr", modelPc, instAddr);
            w = nextInstruction(n);
            pending = predict(w);
            if (pending.wen && pending.rd != 5'd0) modelRegs[pending.rd] = pending.wdata;
            modelPc = pending.nextPc;
            inst = w;
        end
        @(posedge clk);
        #DRIVE_DELAY;
        expQ.push_back(pending);
        wait (checkedCount == N_INST);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // retire compare, half a cycle after each edge
    initial begin
        stepResult_t want;
        forever begin
            @(negedge clk);
            if (rstN) begin
                if (expQ.size() > 0) begin
                    want = expQ.pop_front();
                    checkValue("retire.valid", 64'd1, 64'(retire.valid));
                    checkValue("retire.pc", want.pc, retire.pc);
                    checkValue("retire.inst", 64'(want.inst.raw), 64'(retire.inst.raw));
                    checkValue("retire.wen", 64'(want.wen), 64'(retire.wen));
                    checkValue("retire.rd", 64'(want.rd), 64'(retire.rd));
                    if (want.wen) checkValue("retire.wdata", want.wdata, retire.wdata);
                    checkValue("retire.nextPc", want.nextPc, retire.nextPc);
                    checkedCount++;
                end else if (checkedCount == 0) begin
                    checkValue("retire.valid", 64'd0, 64'(retire.valid));  // nothing run yet
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: only %0d of %0d instructions were checked", checkedCount, N_INST);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+verif
src/rvPkg.sv
src/immDecode.sv
src/regFile.sv
src/execUnit.sv
src/loadStore.sv
src/fetchUnit.sv
src/rvCore.sv
verif/rvCoreTb.sv

/* run.sh */
#!/usr/bin/env bash
# builds and runs the rvCore testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -j 0 -f vlog.f --top-module rvCoreTb -o rvCoreTbSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/rvCoreTbSim 2>&1 | tee "$LOG"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
    echo "simulation exited with an error status"
    exit 1
fi

if grep -q "Verification failed" "$LOG"; then
    exit 1
fi
exit 0
